/* Makefile */
# Verilator build and run of the lc4 core testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_lc4_core
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/lc4_consts.svh */
// word width, register count, reset pc and opcode field bounds, include wherever they are needed
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// data and address width
`define LC4_WORD_W     16
// register select width and register count
`define LC4_REG_SEL_W  3
`define LC4_NUM_REGS   8
// first fetch address after reset
`define LC4_RESET_PC   16'h8200
// opcode field bounds within an instruction word
`define LC4_OPC_HI     15
`define LC4_OPC_LO     12

`endif

/* design/lc4_core.sv */
// top level of the four-stage lc4 core, instruction port in and writeback trace out
module lc4_core
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic     gwe,
   input  logic     i_rst,
   // instruction port, answered in the same cycle
   output word_t    o_cur_pc,
   input  word_t    i_cur_insn,
   // one record per committed instruction
   output logic     o_wb_valid,
   output word_t    o_wb_pc,
   output word_t    o_wb_insn,
   output logic     o_wb_regfile_we,
   output reg_sel_t o_wb_wsel,
   output word_t    o_wb_data,
   output logic     o_wb_nzp_we,
   output nzp_t     o_wb_nzp
);

   reg_read_if rd_if ();

   dx_t   dx;
   xw_t   xw;
   logic  redirect;
   word_t redirect_pc;

   lc4_fetch_decode fetch_decode_i (
      .gwe           (gwe),
      .i_rst         (i_rst),
      .o_cur_pc      (o_cur_pc),
      .i_cur_insn    (i_cur_insn),
      .i_redirect    (redirect),
      .i_redirect_pc (redirect_pc),
      .rd            (rd_if.decoder),
      .o_dx          (dx)
   );

   // written from the writeback register
   lc4_regfile regfile_i (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .rd        (rd_if.regfile),
      .i_wr_en   (xw.regfile_we),
      .i_wr_sel  (xw.wsel),
      .i_wr_data (xw.data)
   );

   lc4_execute execute_i (
      .gwe           (gwe),
      .i_rst         (i_rst),
      .i_dx          (dx),
      .o_redirect    (redirect),
      .o_redirect_pc (redirect_pc),
      .o_xw          (xw)
   );

   // trace straight from the writeback register
   assign o_wb_valid      = xw.valid;
   assign o_wb_pc         = xw.pc;
   assign o_wb_insn       = xw.insn;
   assign o_wb_regfile_we = xw.regfile_we;
   assign o_wb_wsel       = xw.wsel;
   assign o_wb_data       = xw.data;
   assign o_wb_nzp_we     = xw.nzp_we;
   assign o_wb_nzp        = xw.nzp;

endmodule

/* design/lc4_execute.sv */
// execute stage, bypass, alu, nzp and branch resolution, registers the committed result
module lc4_execute
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic  gwe,
   input  logic  i_rst,
   input  dx_t   i_dx,
   output logic  o_redirect,
   output word_t o_redirect_pc,
   output xw_t   o_xw
);

   // operands after bypass
   word_t rs_val;
   word_t rt_val;
   word_t op_b;
   logic  use_imm;
   word_t alu_result;
   // condition codes
   nzp_t  nzp_q;
   nzp_t  nzp_new;
   logic  take_branch;
   // execute-to-writeback register
   xw_t   xw_d;
   xw_t   xw_q;

   // writeback result overrides a stale read of the same register
   // older results already reached decode through write-through
   assign rs_val = (xw_q.regfile_we && (xw_q.wsel == i_dx.rs_sel)) ? xw_q.data
                                                                   : i_dx.rs_data;
   assign rt_val = (xw_q.regfile_we && (xw_q.wsel == i_dx.rt_sel)) ? xw_q.data
                                                                   : i_dx.rt_data;

   // imm5 add has insn bit 5 set, const always takes the immediate
   assign use_imm = i_dx.insn[5] || (i_dx.alu_op == ALU_PASS_B);
   assign op_b    = use_imm ? i_dx.imm : rt_val;

   // results wrap at 16 bits
   always_comb begin
      case (i_dx.alu_op)
         ALU_ADD:    alu_result = rs_val + op_b;
         ALU_SUB:    alu_result = rs_val - op_b;
         ALU_AND:    alu_result = rs_val & op_b;
         ALU_PASS_B: alu_result = op_b;
         default:    alu_result = '0;
      endcase
   end

   // sign of the result as a one-hot code
   always_comb begin
      if (alu_result == '0) begin
         nzp_new = NZP_Z;
      end else if ($signed(alu_result) < 0) begin
         nzp_new = NZP_N;
      end else begin
         nzp_new = NZP_P;
      end
   end

   // updated by every valid register-writing instruction
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         nzp_q <= '0;
      end else if (i_dx.valid && i_dx.nzp_we) begin
         nzp_q <= nzp_new;
      end
   end

   // branch tests the mask against codes left by older instructions
   assign take_branch   = i_dx.valid && i_dx.is_branch && (|(i_dx.nzp & nzp_q));
   assign o_redirect    = take_branch;
   assign o_redirect_pc = i_dx.pc + 16'd1 + i_dx.imm;

   // non-writing commits show zero data and nzp on the trace
   always_comb begin
      xw_d.valid      = i_dx.valid;
      xw_d.pc         = i_dx.pc;
      xw_d.insn       = i_dx.insn;
      xw_d.regfile_we = i_dx.valid & i_dx.regfile_we;
      xw_d.wsel       = i_dx.wsel;
      xw_d.data       = xw_d.regfile_we ? alu_result : '0;
      xw_d.nzp_we     = i_dx.valid & i_dx.nzp_we;
      xw_d.nzp        = xw_d.nzp_we ? nzp_new : '0;
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         xw_q.valid      <= 1'b0;
         xw_q.regfile_we <= 1'b0;
         xw_q.nzp_we     <= 1'b0;
      end else begin
         xw_q <= xw_d;
      end
   end

   assign o_xw = xw_q;

endmodule

/* design/lc4_fetch_decode.sv */
// fetch and decode stages, owns the pc and hands decoded slots with register data to execute
`include "lc4_consts.svh"

module lc4_fetch_decode
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;
(
   input  logic       gwe,
   input  logic       i_rst,
   output word_t      o_cur_pc,
   input  word_t      i_cur_insn,
   input  logic       i_redirect,
   input  word_t      i_redirect_pc,
   reg_read_if.decoder rd,
   output dx_t        o_dx
);

   // program counter
   word_t   pc_q;
   // fetch latch, the slot now in decode
   logic    fd_valid_q;
   word_t   fd_pc_q;
   word_t   fd_insn_q;
   // decoder outputs
   opcode_e opcode;
   alu_op_e dec_alu_op;
   logic    dec_writes;
   logic    dec_is_branch;
   word_t   dec_imm;
   // decode-to-execute register
   logic    slot_live;
   dx_t     dx_d;
   dx_t     dx_q;

   assign o_cur_pc = pc_q;

   // pc steps by one, a taken branch in execute overrides
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc_q <= `LC4_RESET_PC;
      end else if (i_redirect) begin
         pc_q <= i_redirect_pc;
      end else begin
         pc_q <= pc_q + 16'd1;
      end
   end

   // wrong-path fetch becomes a bubble
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         fd_valid_q <= 1'b0;
      end else begin
         fd_valid_q <= ~i_redirect;
      end
   end

   // payload of the fetch latch
   always_ff @(posedge gwe) begin
      fd_pc_q   <= pc_q;
      fd_insn_q <= i_cur_insn;
   end

   assign opcode = opcode_e'(fd_insn_q[`LC4_OPC_HI:`LC4_OPC_LO]);

   // unknown opcodes and sub-ops keep the no-op defaults
   always_comb begin
      dec_alu_op    = ALU_NOP;
      dec_writes    = 1'b0;
      dec_is_branch = 1'b0;
      dec_imm       = '0;
      case (opcode)
         OPC_BR: begin
            dec_is_branch = 1'b1;
            dec_imm       = {{7{fd_insn_q[8]}}, fd_insn_q[8:0]};
         end
         OPC_ARITH: begin
            // bit 5 marks the imm5 form of add
            if (fd_insn_q[5]) begin
               dec_alu_op = ALU_ADD;
               dec_writes = 1'b1;
               dec_imm    = {{11{fd_insn_q[4]}}, fd_insn_q[4:0]};
            end else if (fd_insn_q[5:3] == SUBOP_ADD) begin
               dec_alu_op = ALU_ADD;
               dec_writes = 1'b1;
            end else if (fd_insn_q[5:3] == SUBOP_SUB) begin
               dec_alu_op = ALU_SUB;
               dec_writes = 1'b1;
            end
         end
         OPC_LOGIC: begin
            if (fd_insn_q[5:3] == SUBOP_AND) begin
               dec_alu_op = ALU_AND;
               dec_writes = 1'b1;
            end
         end
         OPC_CONST: begin
            dec_alu_op = ALU_PASS_B;
            dec_writes = 1'b1;
            dec_imm    = {{7{fd_insn_q[8]}}, fd_insn_q[8:0]};
         end
         default: begin
            dec_alu_op = ALU_NOP;
         end
      endcase
   end

   // source selects, rd field doubles as the branch mask
   assign rd.rs_sel = fd_insn_q[8:6];
   assign rd.rt_sel = fd_insn_q[2:0];

   // younger slot is squashed in the same cycle as the redirect
   assign slot_live = fd_valid_q & ~i_redirect;

   always_comb begin
      dx_d.valid      = slot_live;
      dx_d.pc         = fd_pc_q;
      dx_d.insn       = fd_insn_q;
      dx_d.rs_sel     = rd.rs_sel;
      dx_d.rt_sel     = rd.rt_sel;
      dx_d.rs_data    = rd.rs_data;
      dx_d.rt_data    = rd.rt_data;
      dx_d.wsel       = fd_insn_q[11:9];
      dx_d.regfile_we = slot_live & dec_writes;
      dx_d.nzp_we     = slot_live & dec_writes;
      dx_d.is_branch  = slot_live & dec_is_branch;
      dx_d.nzp        = fd_insn_q[11:9];
      dx_d.alu_op     = dec_alu_op;
      dx_d.imm        = dec_imm;
   end

   // only the control bits are cleared
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         dx_q.valid      <= 1'b0;
         dx_q.regfile_we <= 1'b0;
         dx_q.nzp_we     <= 1'b0;
         dx_q.is_branch  <= 1'b0;
      end else begin
         dx_q <= dx_d;
      end
   end

   assign o_dx = dx_q;

endmodule

/* design/lc4_isa_pkg.sv */
// instruction-set types for the lc4 core, imported by the decoder, execute stage and top level
`include "lc4_consts.svh"

package lc4_isa_pkg;

   // machine word and register index
   typedef logic [`LC4_WORD_W-1:0]    word_t;
   typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;

   // condition code, bit 2 negative, bit 1 zero, bit 0 positive
   typedef logic [2:0] nzp_t;

   localparam nzp_t NZP_N = 3'b100;
   localparam nzp_t NZP_Z = 3'b010;
   localparam nzp_t NZP_P = 3'b001;

   // opcodes the decoder knows about
   // everything else falls through to a no-op
   typedef enum logic [3:0] {
      OPC_BR    = 4'b0000,
      OPC_ARITH = 4'b0001,
      OPC_LOGIC = 4'b0101,
      OPC_CONST = 4'b1001
   } opcode_e;

   // sub-op field insn[5:3] for register forms
   localparam logic [2:0] SUBOP_ADD = 3'b000;
   localparam logic [2:0] SUBOP_SUB = 3'b010;
   localparam logic [2:0] SUBOP_AND = 3'b000;

   // alu operation chosen in decode
   // pass_b forwards the immediate, used by const
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_PASS_B = 3'd3,
      ALU_NOP    = 3'd4
   } alu_op_e;

endpackage

/* design/lc4_pipe_pkg.sv */
// payload structs for the decode-to-execute and execute-to-writeback pipeline registers
package lc4_pipe_pkg;

   import lc4_isa_pkg::*;

   // decoded slot entering execute
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      reg_sel_t rs_sel;
      reg_sel_t rt_sel;
      word_t    rs_data;
      word_t    rt_data;
      reg_sel_t wsel;
      logic     regfile_we;
      logic     nzp_we;
      logic     is_branch;
      // branch mask, taken when it overlaps the stored nzp
      nzp_t     nzp;
      alu_op_e  alu_op;
      // already sign extended
      word_t    imm;
   } dx_t;

   // committed result, also the writeback trace
   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    data;
      logic     nzp_we;
      nzp_t     nzp;
   } xw_t;

endpackage

/* design/lc4_regfile.sv */
// eight-entry register file with two combinational read ports and one write-through write port
`include "lc4_consts.svh"

module lc4_regfile
   import lc4_isa_pkg::*;
(
   input  logic       gwe,
   input  logic       i_rst,
   reg_read_if.regfile rd,
   input  logic       i_wr_en,
   input  reg_sel_t   i_wr_sel,
   input  word_t      i_wr_data
);

   word_t regs_q [`LC4_NUM_REGS];

   // write on the edge, whole file cleared on reset
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (i_wr_en) begin
         regs_q[i_wr_sel] <= i_wr_data;
      end
   end

   // write-through so decode sees the value committing this cycle
   assign rd.rs_data = (i_wr_en && (i_wr_sel == rd.rs_sel)) ? i_wr_data
                                                             : regs_q[rd.rs_sel];
   assign rd.rt_data = (i_wr_en && (i_wr_sel == rd.rt_sel)) ? i_wr_data
                                                             : regs_q[rd.rt_sel];

endmodule

/* design/reg_read_if.sv */
// register read bundle, decode drives the selects and the register file returns data
interface reg_read_if import lc4_isa_pkg::*; ();

   // selects from the decoder
   reg_sel_t rs_sel;
   reg_sel_t rt_sel;
   // combinational read data, same cycle
   word_t    rs_data;
   word_t    rt_data;

   modport decoder (
      output rs_sel,
      output rt_sel,
      input  rs_data,
      input  rt_data
   );

   modport regfile (
      input  rs_sel,
      input  rt_sel,
      output rs_data,
      output rt_data
   );

endinterface

/* filelist.f */
+incdir+design
design/lc4_isa_pkg.sv
design/lc4_pipe_pkg.sv
design/reg_read_if.sv
design/lc4_regfile.sv
design/lc4_fetch_decode.sv
design/lc4_execute.sv
design/lc4_core.sv
verification/lc4_core_chk.sv
verification/tb_lc4_core.sv

/* verification/lc4_core_chk.sv */
// assertions on the lc4 core writeback trace, bound into every lc4_core instance
module lc4_core_chk
   import lc4_isa_pkg::*;
(
   input logic gwe,
   input logic i_rst,
   input logic i_wb_valid,
   input logic i_wb_regfile_we,
   input logic i_wb_nzp_we,
   input nzp_t i_wb_nzp
);

   // write enables only travel with a committed slot
   trace_we_needs_valid: assert property (@(posedge gwe) disable iff (i_rst)
      (i_wb_regfile_we || i_wb_nzp_we) |-> i_wb_valid)
      else $error("trace write enable high while o_wb_valid is low");

   // exactly one condition bit when nzp is written
   trace_nzp_onehot: assert property (@(posedge gwe) disable iff (i_rst)
      i_wb_nzp_we |-> $onehot(i_wb_nzp))
      else $error("o_wb_nzp is not one-hot while o_wb_nzp_we is high");

   // sync reset, so check from the edge after reset was seen
   trace_quiet_in_reset: assert property (@(posedge gwe)
      $past(i_rst) |-> !i_wb_valid)
      else $error("o_wb_valid high while reset is held");

endmodule

bind lc4_core lc4_core_chk chk_i (
   .gwe             (gwe),
   .i_rst           (i_rst),
   .i_wb_valid      (o_wb_valid),
   .i_wb_regfile_we (o_wb_regfile_we),
   .i_wb_nzp_we     (o_wb_nzp_we),
   .i_wb_nzp        (o_wb_nzp)
);

/* verification/lc4_core_patterns.txt */
# P <addr> <insn>  program word, hex
# E <pc> <insn> <regfile_we> <wsel> <data> <nzp_we> <nzp>  commit in order, nzp binary
# wsel and data are ignored when regfile_we is 0, nzp when nzp_we is 0
P 8200 9005  # const r0, 5
P 8201 93fd  # const r1, -3
P 8202 1401  # add r2, r0, r1
P 8203 1690  # sub r3, r2, r0
P 8204 58c0  # and r4, r3, r0
P 8205 1b3b  # add r5, r4, #-5
P 8206 0402  # brz +2, taken
P 8207 9c01  # wrong path
P 8208 9c02  # wrong path
P 8209 1d6f  # add r6, r5, #15
P 820a 0803  # brn +3, not taken
P 820b 6e45  # unsupported opcode
P 820c 9eff  # const r7, 255
P 820d 1fc7  # add r7, r7, r7
P 820e 9100  # const r0, -256
P 820f 1000  # add r0, r0, r0, wraps
P 8210 1250  # sub r1, r1, r0
P 8211 0202  # brp +2, taken
P 8212 9409  # wrong path
P 8213 9609  # wrong path
P 8214 5443  # and r2, r1, r3
P 8215 1a92  # sub r5, r2, r2
P 8216 0a05  # brnp +5, not taken
P 8217 05f8  # brz -8, taken back to 8210
E 8200 9005 1 0 0005 1 001
E 8201 93fd 1 1 fffd 1 100
E 8202 1401 1 2 0002 1 001
E 8203 1690 1 3 fffd 1 100
E 8204 58c0 1 4 0005 1 001
E 8205 1b3b 1 5 0000 1 010
E 8206 0402 0 0 0000 0 000
E 8209 1d6f 1 6 000f 1 001
E 820a 0803 0 0 0000 0 000
E 820b 6e45 0 0 0000 0 000
E 820c 9eff 1 7 00ff 1 001
E 820d 1fc7 1 7 01fe 1 001
E 820e 9100 1 0 ff00 1 100
E 820f 1000 1 0 fe00 1 100
E 8210 1250 1 1 01fd 1 001
E 8211 0202 0 0 0000 0 000
E 8214 5443 1 2 01fd 1 001
E 8215 1a92 1 5 0000 1 010
E 8216 0a05 0 0 0000 0 000
E 8217 05f8 0 0 0000 0 000
E 8210 1250 1 1 03fd 1 001
E 8211 0202 0 0 0000 0 000

/* verification/tb_lc4_core.sv */
// testbench for lc4_core, runs the program from the pattern file and checks each commit in order
module tb_lc4_core
   import lc4_isa_pkg::*;
();

   // one expected commit
   typedef struct packed {
      word_t    pc;
      word_t    insn;
      logic     regfile_we;
      reg_sel_t wsel;
      word_t    data;
      logic     nzp_we;
      nzp_t     nzp;
   } commit_t;

   logic     gwe;
   logic     i_rst;
   word_t    cur_pc;
   word_t    cur_insn;
   logic     wb_valid;
   word_t    wb_pc;
   word_t    wb_insn;
   logic     wb_regfile_we;
   reg_sel_t wb_wsel;
   word_t    wb_data;
   logic     wb_nzp_we;
   nzp_t     wb_nzp;

   // sparse program image keyed by address
   word_t    imem [word_t];
   commit_t  expected_q [$];
   int       num_prog;
   int       num_expected;
   int       commits;
   int       cycles;
   int       cycle_limit;

   lc4_core dut_i (
      .gwe             (gwe),
      .i_rst           (i_rst),
      .o_cur_pc        (cur_pc),
      .i_cur_insn      (cur_insn),
      .o_wb_valid      (wb_valid),
      .o_wb_pc         (wb_pc),
      .o_wb_insn       (wb_insn),
      .o_wb_regfile_we (wb_regfile_we),
      .o_wb_wsel       (wb_wsel),
      .o_wb_data       (wb_data),
      .o_wb_nzp_we     (wb_nzp_we),
      .o_wb_nzp        (wb_nzp)
   );

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   task automatic abort_run(string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_value(string name, logic [15:0] expected, logic [15:0] actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error: time %0t, %s expected 0x%04h, got 0x%04h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_commit(commit_t rec);
      check_value("o_wb_pc", rec.pc, wb_pc);
      check_value("o_wb_insn", rec.insn, wb_insn);
      check_value("o_wb_regfile_we", 16'(rec.regfile_we), 16'(wb_regfile_we));
      check_value("o_wb_nzp_we", 16'(rec.nzp_we), 16'(wb_nzp_we));
      // wsel and data only mean something for a register write
      if (rec.regfile_we) begin
         check_value("o_wb_wsel", 16'(rec.wsel), 16'(wb_wsel));
         check_value("o_wb_data", rec.data, wb_data);
      end
      if (rec.nzp_we) begin
         check_value("o_wb_nzp", 16'(rec.nzp), 16'(wb_nzp));
      end
   endtask

   // unlisted addresses read as 0000, a branch with empty mask
   function automatic word_t fetch_word(word_t addr);
      if (imem.exists(addr)) begin
         return imem[addr];
      end
      return 16'h0000;
   endfunction

   // P lines fill the program, E lines queue expected commits
   task automatic load_patterns();
      int          fd;
      string       line;
      logic [15:0] f0, f1, f2, f3, f4, f5;
      logic [2:0]  f6;
      commit_t     rec;
      fd = $fopen("verification/lc4_core_patterns.txt", "r");
      if (fd == 0) begin
         abort_run("could not open verification/lc4_core_patterns.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if ($sscanf(line, "P %h %h", f0, f1) == 2) begin
            imem[f0] = f1;
            num_prog++;
         end else if ($sscanf(line, "E %h %h %h %h %h %h %b",
                              f0, f1, f2, f3, f4, f5, f6) == 7) begin
            rec.pc         = f0;
            rec.insn       = f1;
            rec.regfile_we = f2[0];
            rec.wsel       = f3[2:0];
            rec.data       = f4;
            rec.nzp_we     = f5[0];
            rec.nzp        = f6;
            expected_q.push_back(rec);
         end
      end
      $fclose(fd);
   endtask

   // drive on the falling edge, sample the registered trace there too
   always @(negedge gwe) begin
      cur_insn <= fetch_word(cur_pc);
      if (wb_valid === 1'b1) begin
         if (i_rst) begin
            abort_run("a commit appeared while reset was held");
         end else if (commits < num_expected) begin
            check_commit(expected_q[commits]);
            commits++;
         end
      end
   end

   initial begin
      i_rst    = 1'b1;
      cur_insn = 16'h0000;
      num_prog = 0;
      commits  = 0;
      cycles   = 0;
      load_patterns();
      num_expected = expected_q.size();
      if (num_prog == 0 || num_expected == 0) begin
         abort_run("the pattern file holds no program or no expected commits");
      end
      // bound on run length, grows with the program
      cycle_limit = 4 * num_prog + 40;
      repeat (8) @(negedge gwe);
      i_rst <= 1'b0;
      while (commits < num_expected && cycles < cycle_limit) begin
         @(posedge gwe);
         cycles++;
      end
      if (commits == num_expected) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         abort_run($sformatf("timeout, only %0d of %0d commits seen after %0d cycles",
                             commits, num_expected, cycles));
      end
   end

endmodule
